// File: Bender.yml
package:
  name: arm_pipeline

sources:
  - src/cpu_pkg.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/register_file.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_props.sv
      - dv/cpu_tb.sv

// File: dv/cpu_props.sv
module cpu_props import cpu_pkg::*; (
  input logic                     clk,
  input logic                     nreset,
  input logic [data_width-1:0]    pc,
  input logic                     retire_valid,
  input logic [reg_idx_width-1:0] retire_reg
);

  // a reset edge leaves the retire port quiet
  property retire_quiet_in_reset;
    @(posedge clk) !nreset |=> !retire_valid;
  endproperty

  // r15 is never a write-back target
  property retire_not_pc;
    @(posedge clk) disable iff (!nreset) retire_valid |-> retire_reg != reg_pc;
  endproperty

  property pc_aligned;
    @(posedge clk) disable iff (!nreset) pc[1:0] == 2'b00;
  endproperty

  assert property (retire_quiet_in_reset)
    else $error("retire_valid high after a reset edge");

  assert property (retire_not_pc)
    else $error("retirement to r15");

  assert property (pc_aligned)
    else $error("pc not word aligned");

endmodule

bind cpu_top cpu_props u_props (.*);

// File: dv/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

  localparam int clk_half      = 10;
  localparam int reset_cycles  = 3;
  localparam int idle_cycles   = 16;
  localparam int cycle_limit   = code_words * 8 + 20;

  logic                       clk;
  logic                       nreset;
  logic                       code_we;
  logic [code_addr_width-1:0] code_addr;
  logic [data_width-1:0]      code_wdata;
  logic                       led;
  logic [data_width-1:0]      pc;
  logic                       retire_valid;
  logic [reg_idx_width-1:0]   retire_reg;
  logic [data_width-1:0]      retire_data;

  // program table with one row per code word
  logic [data_width-1:0]    prog_word   [code_words];
  string                    prog_text   [code_words];
  bit                       prog_retire [code_words];
  logic [reg_idx_width-1:0] prog_reg    [code_words];
  logic [data_width-1:0]    prog_value  [code_words];
  int                       prog_gap    [code_words];

  int row_count;
  int cycle_count;

  cpu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #clk_half clk = ~clk;
    end
  end

  ////////////////////
  // helpers

  task automatic check_value(input string what, input logic [data_width-1:0] actual,
                             input logic [data_width-1:0] expected);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic add_row(input logic [data_width-1:0] word, input string text,
                         input bit retires, input logic [reg_idx_width-1:0] rd,
                         input logic [data_width-1:0] value, input int gap);
    prog_word[row_count]   = word;
    prog_text[row_count]   = text;
    prog_retire[row_count] = retires;
    prog_reg[row_count]    = rd;
    prog_value[row_count]  = value;
    prog_gap[row_count]    = gap;
    row_count++;
  endtask

  // gap is the number of cycles since the previous retirement,
  // or since reset release for the first one
  task automatic build_program();
    row_count = 0;
    add_row(32'he3a0100c, "mov r1, #12",       1'b1, 4'd1,  32'd12,       4);
    add_row(32'he2612014, "rsb r2, r1, #20",   1'b1, 4'd2,  32'd8,        1);
    add_row(32'he0813002, "add r3, r1, r2",    1'b1, 4'd3,  32'd20,       1);
    add_row(32'he0034001, "and r4, r3, r1",    1'b1, 4'd4,  32'd4,        1);
    add_row(32'he1845002, "orr r5, r4, r2",    1'b1, 4'd5,  32'd12,       1);
    add_row(32'he0256003, "eor r6, r5, r3",    1'b1, 4'd6,  32'd24,       1);
    add_row(32'he1c67002, "bic r7, r6, r2",    1'b1, 4'd7,  32'd16,       1);
    add_row(32'he0558001, "subs r8, r5, r1",   1'b1, 4'd8,  32'd0,        1);
    // z is set so this one falls through
    add_row(32'h1a000004, "bne 56",            1'b0, 4'd0,  32'd0,        0);
    add_row(32'h0b000004, "bleq 60",           1'b1, 4'd14, 32'd40,       2);
    // two bubbles behind bleq and two behind bx
    add_row(32'he2a29001, "adc r9, r2, #1",    1'b1, 4'd9,  32'd10,       6);
    add_row(32'he5819004, "str r9, [r1, #4]",  1'b0, 4'd0,  32'd0,        0);
    add_row(32'he591a004, "ldr r10, [r1, #4]", 1'b1, 4'd10, 32'd10,       2);
    add_row(32'he1e0b003, "mvn r11, r3",       1'b1, 4'd11, 32'hffffffeb, 1);
    add_row(32'heafffffe, "b 56",              1'b0, 4'd0,  32'd0,        0);
    // subroutine only reached through bleq
    add_row(32'he12fff1e, "bx r14",            1'b0, 4'd0,  32'd0,        0);
  endtask

  task automatic wait_retire(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (retire_valid !== 1'b1);
  endtask

  ////////////////////
  // main sequence

  initial begin
    int gap;

    nreset      = 1'b0;
    code_we     = 1'b0;
    code_addr   = '0;
    code_wdata  = '0;
    build_program();

    // core stays in reset while the program is written
    for (int i = 0; i < row_count; i++) begin
      @(negedge clk);
      check_value("retire_valid in reset", retire_valid, 1'b0);
      code_we    = 1'b1;
      code_addr  = code_addr_width'(i);
      code_wdata = prog_word[i];
    end
    repeat (reset_cycles) begin
      @(negedge clk);
      code_we = 1'b0;
      check_value("retire_valid in reset", retire_valid, 1'b0);
    end
    check_value("pc in reset", pc, '0);
    nreset = 1'b1;

    for (int i = 0; i < row_count; i++) begin
      if (prog_retire[i]) begin
        wait_retire(gap);
        check_value({prog_text[i], " retire gap"}, gap, prog_gap[i]);
        check_value({prog_text[i], " retire_reg"}, retire_reg, prog_reg[i]);
        check_value({prog_text[i], " retire_data"}, retire_data, prog_value[i]);
      end
    end

    // the final self loop must retire nothing
    repeat (idle_cycles) begin
      @(negedge clk);
      check_value("retire_valid in the final loop", retire_valid, 1'b0);
    end

    $display("TEST PASSED");
    $finish;
  end

  // led mirrors pc bit 2
  always @(negedge clk) begin
    check_value("led", led, pc[2]);
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the program did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped by the cycle limit");
  end

endmodule

// File: files.f
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/register_file.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_top.sv
dv/cpu_props.sv
dv/cpu_tb.sv

// File: src/cpu_pkg.sv
package cpu_pkg;

  ////////////////////
  // widths and depths

  localparam int data_width      = 32;
  localparam int code_words      = 16;
  localparam int code_addr_width = 4;
  localparam int data_words      = 8;
  localparam int data_addr_width = 3;
  localparam int reg_idx_width   = 4;

  localparam logic [reg_idx_width-1:0] reg_pc = 4'd15;
  localparam logic [reg_idx_width-1:0] reg_lr = 4'd14;

  // instruction class, bits 27:26
  localparam logic [1:0] type_dp = 2'b00;
  localparam logic [1:0] type_ls = 2'b01;
  localparam logic [1:0] type_br = 2'b10;

  // bits 27:4 of bx, rm sits below
  localparam logic [23:0] bx_pattern = 24'h12fff1;

  ////////////////////
  // alu opcodes

  localparam logic [3:0] opcode_and = 4'b0000;
  localparam logic [3:0] opcode_eor = 4'b0001;
  localparam logic [3:0] opcode_sub = 4'b0010;
  localparam logic [3:0] opcode_rsb = 4'b0011;
  localparam logic [3:0] opcode_add = 4'b0100;
  localparam logic [3:0] opcode_adc = 4'b0101;
  localparam logic [3:0] opcode_sbc = 4'b0110;
  localparam logic [3:0] opcode_rsc = 4'b0111;
  localparam logic [3:0] opcode_tst = 4'b1000;
  localparam logic [3:0] opcode_teq = 4'b1001;
  localparam logic [3:0] opcode_cmp = 4'b1010;
  localparam logic [3:0] opcode_cmn = 4'b1011;
  localparam logic [3:0] opcode_orr = 4'b1100;
  localparam logic [3:0] opcode_mov = 4'b1101;
  localparam logic [3:0] opcode_bic = 4'b1110;
  localparam logic [3:0] opcode_mvn = 4'b1111;

  ////////////////////
  // condition codes

  localparam logic [3:0] cond_eq = 4'b0000;
  localparam logic [3:0] cond_ne = 4'b0001;
  localparam logic [3:0] cond_cs = 4'b0010;
  localparam logic [3:0] cond_cc = 4'b0011;
  localparam logic [3:0] cond_mi = 4'b0100;
  localparam logic [3:0] cond_pl = 4'b0101;
  localparam logic [3:0] cond_vs = 4'b0110;
  localparam logic [3:0] cond_vc = 4'b0111;
  localparam logic [3:0] cond_hi = 4'b1000;
  localparam logic [3:0] cond_ls = 4'b1001;
  localparam logic [3:0] cond_ge = 4'b1010;
  localparam logic [3:0] cond_lt = 4'b1011;
  localparam logic [3:0] cond_gt = 4'b1100;
  localparam logic [3:0] cond_le = 4'b1101;
  localparam logic [3:0] cond_al = 4'b1110;

  // bit positions in the 4-bit flag register
  localparam int flag_n = 3;
  localparam int flag_z = 2;
  localparam int flag_c = 1;
  localparam int flag_v = 0;

  // one instruction word, three field layouts
  typedef union packed {
    logic [data_width-1:0] raw;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  inst_type;
      logic        imm;
      logic [3:0]  opcode;
      logic        s;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2;
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  inst_type;
      logic        i;
      logic        p;
      logic        u;
      logic        b;
      logic        w;
      logic        load;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset;
    } ls;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  inst_type;
      logic        fixed;
      logic        link;
      logic [23:0] offset;
    } br;
  } inst_word_u;

endpackage

// File: src/cpu_top.sv
module cpu_top import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       code_we,
  input  logic [code_addr_width-1:0] code_addr,
  input  logic [data_width-1:0]      code_wdata,
  output logic                       led,
  output logic [data_width-1:0]      pc,
  output logic                       retire_valid,
  output logic [reg_idx_width-1:0]   retire_reg,
  output logic [data_width-1:0]      retire_data
);

  // fetch to decode
  inst_word_u               fd_inst;
  logic [data_width-1:0]    fd_pc;
  logic                     fd_valid;

  // register file read side
  logic [reg_idx_width-1:0] rs1;
  logic [reg_idx_width-1:0] rs2;
  logic [data_width-1:0]    rd1;
  logic [data_width-1:0]    rd2;

  // decode to execute
  inst_word_u               de_inst;
  logic [data_width-1:0]    de_pc;
  logic                     de_valid;
  logic [data_width-1:0]    de_op1;
  logic [data_width-1:0]    de_op2;
  logic [data_width-1:0]    de_store_data;
  logic [data_width-1:0]    de_target;
  logic                     de_we;
  logic [reg_idx_width-1:0] de_reg;

  // branch control
  logic                     redirect;
  logic [data_width-1:0]    redirect_pc;
  logic                     flush;

  // execute to memory
  logic                     em_valid;
  logic                     em_we;
  logic [reg_idx_width-1:0] em_reg;
  logic [data_width-1:0]    em_data;
  logic                     em_store;
  logic                     em_load;
  logic [data_width-1:0]    em_addr;

  // memory to write-back
  logic                     mw_we;
  logic [reg_idx_width-1:0] mw_reg;
  logic [data_width-1:0]    mw_data;

  assign led          = pc[2];
  assign retire_valid = mw_we;
  assign retire_reg   = mw_reg;
  assign retire_data  = mw_data;

  fetch_stage u_fetch (.*);

  decode_stage u_decode (.*);

  register_file u_regs (
    .clk,
    .nreset,
    .rs1,
    .rs2,
    .pc_in   (de_pc),
    .rd1,
    .rd2,
    .wb_we   (mw_we),
    .wb_reg  (mw_reg),
    .wb_data (mw_data)
  );

  execute_stage u_execute (.*);

  memory_stage u_memory (.*);

endmodule

// File: src/decode_stage.sv
module decode_stage import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     nreset,
  input  logic                     flush,
  input  inst_word_u               fd_inst,
  input  logic [data_width-1:0]    fd_pc,
  input  logic                     fd_valid,
  output logic [reg_idx_width-1:0] rs1,
  output logic [reg_idx_width-1:0] rs2,
  input  logic [data_width-1:0]    rd1,
  input  logic [data_width-1:0]    rd2,
  input  logic                     em_we,
  input  logic [reg_idx_width-1:0] em_reg,
  input  logic [data_width-1:0]    em_data,
  input  logic                     mw_we,
  input  logic [reg_idx_width-1:0] mw_reg,
  input  logic [data_width-1:0]    mw_data,
  output inst_word_u               de_inst,
  output logic [data_width-1:0]    de_pc,
  output logic                     de_valid,
  output logic [data_width-1:0]    de_op1,
  output logic [data_width-1:0]    de_op2,
  output logic [data_width-1:0]    de_store_data,
  output logic [data_width-1:0]    de_target,
  output logic                     de_we,
  output logic [reg_idx_width-1:0] de_reg
);

  logic                     fd_bx;
  logic                     de_bx;
  logic                     dec_we;
  logic [reg_idx_width-1:0] dec_reg;
  logic [reg_idx_width-1:0] dec_rs2;
  logic [data_width-1:0]    op_a;
  logic [data_width-1:0]    op_b;
  logic [data_width-1:0]    ls_offset;
  logic [data_width-1:0]    br_offset;

  ////////////////////
  // field decode

  assign fd_bx = fd_inst.raw[27:4] == bx_pattern;

  // stores read rd as data, everything else reads rm
  assign dec_rs2 = (fd_inst.ls.inst_type == type_ls && !fd_inst.ls.load) ?
                   fd_inst.ls.rd : fd_inst.dp.operand2[3:0];

  always_comb begin
    dec_we  = 1'b0;
    dec_reg = fd_inst.dp.rd;
    if (!fd_bx) begin
      case (fd_inst.dp.inst_type)
        type_dp: dec_we = !(fd_inst.dp.opcode inside
                            {opcode_tst, opcode_teq, opcode_cmp, opcode_cmn});
        type_ls: dec_we = fd_inst.ls.load;
        type_br: begin
          dec_we  = fd_inst.br.link;
          dec_reg = reg_lr;
        end
        default: dec_we = 1'b0;
      endcase
    end
    // r15 is not a writable destination here
    if (dec_reg == reg_pc) begin
      dec_we = 1'b0;
    end
  end

  ////////////////////
  // decode/execute register

  always_ff @(posedge clk) begin
    if (!nreset) begin
      de_valid <= 1'b0;
      de_we    <= 1'b0;
    end else begin
      de_valid <= fd_valid && !flush;
      de_we    <= dec_we;
    end
  end

  always_ff @(posedge clk) begin
    de_inst <= fd_inst;
    de_pc   <= fd_pc;
    de_reg  <= dec_reg;
    rs1     <= fd_inst.dp.rn;
    rs2     <= dec_rs2;
  end

  ////////////////////
  // operands

  // read off the registered indices, so em already holds the previous
  // instruction and mw the one before it
  assign op_a = (em_we && em_reg == rs1) ? em_data :
                (mw_we && mw_reg == rs1) ? mw_data : rd1;
  assign op_b = (em_we && em_reg == rs2) ? em_data :
                (mw_we && mw_reg == rs2) ? mw_data : rd2;

  assign de_bx     = de_inst.raw[27:4] == bx_pattern;
  assign ls_offset = {{(data_width-12){1'b0}}, de_inst.ls.offset};
  assign br_offset = {{(data_width-26){de_inst.br.offset[23]}}, de_inst.br.offset, 2'b00};

  always_comb begin
    case (de_inst.dp.inst_type)
      // u bit picks up or down
      type_ls: de_op2 = de_inst.ls.u ? ls_offset : '0 - ls_offset;
      type_dp: de_op2 = de_inst.dp.imm ?
                        {{(data_width-8){1'b0}}, de_inst.dp.operand2[7:0]} : op_b;
      default: de_op2 = op_b;
    endcase
  end

  assign de_op1        = op_a;
  assign de_store_data = op_b;
  // bx drops the low bits, no thumb state
  assign de_target     = de_bx ? {op_b[data_width-1:2], 2'b00} : de_pc + 8 + br_offset;

endmodule

// File: src/execute_stage.sv
module execute_stage import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     nreset,
  input  inst_word_u               de_inst,
  input  logic [data_width-1:0]    de_pc,
  input  logic                     de_valid,
  input  logic [data_width-1:0]    de_op1,
  input  logic [data_width-1:0]    de_op2,
  input  logic [data_width-1:0]    de_store_data,
  input  logic [data_width-1:0]    de_target,
  input  logic                     de_we,
  input  logic [reg_idx_width-1:0] de_reg,
  output logic                     redirect,
  output logic [data_width-1:0]    redirect_pc,
  output logic                     flush,
  output logic                     em_valid,
  output logic                     em_we,
  output logic [reg_idx_width-1:0] em_reg,
  output logic [data_width-1:0]    em_data,
  output logic                     em_store,
  output logic                     em_load,
  output logic [data_width-1:0]    em_addr
);

  logic [3:0]            flags;
  logic                  is_bx;
  logic                  is_branch;
  logic                  is_dp;
  logic                  is_ls;
  logic                  is_arith;
  logic                  cond_ok;
  logic                  taken;
  logic [data_width-1:0] add_x;
  logic [data_width-1:0] add_y;
  logic                  add_cin;
  logic [data_width:0]   sum;
  logic                  sum_v;
  logic [data_width-1:0] alu_result;

  assign is_bx     = de_inst.raw[27:4] == bx_pattern;
  assign is_branch = is_bx || de_inst.br.inst_type == type_br;
  assign is_dp     = !is_bx && de_inst.dp.inst_type == type_dp;
  assign is_ls     = de_inst.ls.inst_type == type_ls;

  ////////////////////
  // alu

  // all arithmetic ops share one adder, subtraction via inverted input
  always_comb begin
    add_x    = de_op1;
    add_y    = de_op2;
    add_cin  = 1'b0;
    is_arith = 1'b1;
    case (de_inst.dp.opcode)
      opcode_add, opcode_cmn: is_arith = 1'b1;
      opcode_adc: add_cin = flags[flag_c];
      opcode_sub, opcode_cmp: begin
        add_y   = ~de_op2;
        add_cin = 1'b1;
      end
      opcode_sbc: begin
        add_y   = ~de_op2;
        add_cin = flags[flag_c];
      end
      opcode_rsb: begin
        add_x   = de_op2;
        add_y   = ~de_op1;
        add_cin = 1'b1;
      end
      opcode_rsc: begin
        add_x   = de_op2;
        add_y   = ~de_op1;
        add_cin = flags[flag_c];
      end
      default: is_arith = 1'b0;
    endcase
  end

  assign sum   = {1'b0, add_x} + {1'b0, add_y} + add_cin;
  // same-sign inputs, different-sign result
  assign sum_v = (add_x[data_width-1] == add_y[data_width-1]) &&
                 (sum[data_width-1] != add_x[data_width-1]);

  always_comb begin
    case (de_inst.dp.opcode)
      opcode_and, opcode_tst: alu_result = de_op1 & de_op2;
      opcode_eor, opcode_teq: alu_result = de_op1 ^ de_op2;
      opcode_orr:             alu_result = de_op1 | de_op2;
      opcode_mov:             alu_result = de_op2;
      opcode_bic:             alu_result = de_op1 & ~de_op2;
      opcode_mvn:             alu_result = ~de_op2;
      default:                alu_result = sum[data_width-1:0];
    endcase
  end

  // logical ops leave c and v alone, there is no shifter carry
  always_ff @(posedge clk) begin
    if (!nreset) begin
      flags <= '0;
    end else if (de_valid && is_dp && de_inst.dp.s) begin
      flags[flag_n] <= alu_result[data_width-1];
      flags[flag_z] <= alu_result == '0;
      if (is_arith) begin
        flags[flag_c] <= sum[data_width];
        flags[flag_v] <= sum_v;
      end
    end
  end

  ////////////////////
  // branch resolve

  always_comb begin
    case (de_inst.br.cond)
      cond_eq: cond_ok = flags[flag_z];
      cond_ne: cond_ok = !flags[flag_z];
      cond_cs: cond_ok = flags[flag_c];
      cond_cc: cond_ok = !flags[flag_c];
      cond_mi: cond_ok = flags[flag_n];
      cond_pl: cond_ok = !flags[flag_n];
      cond_vs: cond_ok = flags[flag_v];
      cond_vc: cond_ok = !flags[flag_v];
      cond_hi: cond_ok = flags[flag_c] && !flags[flag_z];
      cond_ls: cond_ok = !flags[flag_c] || flags[flag_z];
      cond_ge: cond_ok = flags[flag_n] == flags[flag_v];
      cond_lt: cond_ok = flags[flag_n] != flags[flag_v];
      cond_gt: cond_ok = !flags[flag_z] && (flags[flag_n] == flags[flag_v]);
      cond_le: cond_ok = flags[flag_z] || (flags[flag_n] != flags[flag_v]);
      cond_al: cond_ok = 1'b1;
      default: cond_ok = 1'b0;
    endcase
  end

  assign taken       = de_valid && is_branch && cond_ok;
  assign redirect    = taken;
  assign redirect_pc = de_target;
  assign flush       = taken;

  ////////////////////
  // execute/memory register

  always_ff @(posedge clk) begin
    if (!nreset) begin
      em_valid <= 1'b0;
      em_we    <= 1'b0;
      em_store <= 1'b0;
      em_load  <= 1'b0;
    end else begin
      em_valid <= de_valid;
      em_we    <= de_valid && de_we;
      em_store <= is_ls && !de_inst.ls.load;
      em_load  <= is_ls && de_inst.ls.load;
    end
  end

  always_ff @(posedge clk) begin
    em_reg  <= de_reg;
    em_addr <= de_op1 + de_op2;
    if (is_branch) begin
      // link value, only bl writes it back
      em_data <= de_pc + 4;
    end else if (is_ls) begin
      em_data <= de_store_data;
    end else begin
      em_data <= alu_result;
    end
  end

endmodule

// File: src/fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       code_we,
  input  logic [code_addr_width-1:0] code_addr,
  input  logic [data_width-1:0]      code_wdata,
  input  logic                       redirect,
  input  logic [data_width-1:0]      redirect_pc,
  input  logic                       flush,
  output logic [data_width-1:0]      pc,
  output inst_word_u                 fd_inst,
  output logic [data_width-1:0]      fd_pc,
  output logic                       fd_valid
);

  logic [data_width-1:0] code_mem [code_words];

  // loader writes here while the core is held in reset
  always_ff @(posedge clk) begin
    if (code_we) begin
      code_mem[code_addr] <= code_wdata;
    end
  end

  ////////////////////
  // program counter

  always_ff @(posedge clk) begin
    if (!nreset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + 4;
    end
  end

  ////////////////////
  // fetch/decode register

  always_ff @(posedge clk) begin
    if (!nreset) begin
      fd_valid <= 1'b0;
    end else begin
      // word behind a taken branch is dropped
      fd_valid <= !flush;
    end
  end

  always_ff @(posedge clk) begin
    fd_inst.raw <= code_mem[pc[code_addr_width+1:2]];
    fd_pc       <= pc;
  end

endmodule

// File: src/memory_stage.sv
module memory_stage import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     nreset,
  input  logic                     em_valid,
  input  logic                     em_we,
  input  logic [reg_idx_width-1:0] em_reg,
  input  logic [data_width-1:0]    em_data,
  input  logic                     em_store,
  input  logic                     em_load,
  input  logic [data_width-1:0]    em_addr,
  output logic                     mw_we,
  output logic [reg_idx_width-1:0] mw_reg,
  output logic [data_width-1:0]    mw_data
);

  logic [data_width-1:0]      data_mem [data_words];
  logic [data_addr_width-1:0] data_idx;

  // word index, upper address bits wrap
  assign data_idx = em_addr[data_addr_width+1:2];

  always_ff @(posedge clk) begin
    if (em_valid && em_store) begin
      data_mem[data_idx] <= em_data;
    end
  end

  ////////////////////
  // memory/write-back register

  always_ff @(posedge clk) begin
    if (!nreset) begin
      mw_we <= 1'b0;
    end else begin
      mw_we <= em_we;
    end
  end

  always_ff @(posedge clk) begin
    mw_reg  <= em_reg;
    mw_data <= em_load ? data_mem[data_idx] : em_data;
  end

endmodule

// File: src/register_file.sv
module register_file import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     nreset,
  input  logic [reg_idx_width-1:0] rs1,
  input  logic [reg_idx_width-1:0] rs2,
  input  logic [data_width-1:0]    pc_in,
  output logic [data_width-1:0]    rd1,
  output logic [data_width-1:0]    rd2,
  input  logic                     wb_we,
  input  logic [reg_idx_width-1:0] wb_reg,
  input  logic [data_width-1:0]    wb_data
);

  // r0..r14, r15 is not stored
  logic [data_width-1:0] regs [0:reg_pc-1];

  // r15 reads as instruction address plus 8
  assign rd1 = (rs1 == reg_pc) ? pc_in + 8 : regs[rs1];
  assign rd2 = (rs2 == reg_pc) ? pc_in + 8 : regs[rs2];

  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < reg_pc; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_reg != reg_pc) begin
      regs[wb_reg] <= wb_data;
    end
  end

endmodule
